/* verilog/hid_bus_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus side definitions: request struct, region numbers,
// keyboard status layout and the read word union
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package hid_bus_pkg;

  // one bus access, held by the master for a single cycle
  typedef struct packed {
    logic        en;     // access strobe
    logic [7:0]  we;     // byte lanes, all zero means read
    logic [19:0] addr;   // byte address inside the window
    logic [63:0] wdata;
  } hid_req_t;

  // region number lives in addr[19:15]
  localparam logic [4:0] region_kbd = 5'd6;  // keyboard fifo and status
  localparam logic [4:0] region_chr = 5'd7;  // character store

  // keyboard status word as the processor sees it
  typedef struct packed {
    logic [51:0] zero;       // unused, reads 0
    logic        overflow;   // sticky, fifo dropped an event
    logic        frame_err;  // sticky, bad parity or stop bit
    logic        empty;      // no event waiting
    logic        released;   // head event was a break
    logic [7:0]  code;       // head scan code
  } kbd_status_t;

  // one read word, decoded per region
  typedef union packed {
    logic [63:0] raw;  // character store word
    kbd_status_t kbd;  // keyboard register view
  } hid_rdata_u;

endpackage

`default_nettype wire

/* verilog/ps2_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ps2 frame constants and the scan event record
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package ps2_pkg;

  // prefix byte sent ahead of a key release
  localparam logic [7:0] break_code = 8'hF0;

  // start + 8 data + parity + stop
  localparam int frame_bits = 11;

  // one key event as queued for the processor
  typedef struct packed {
    logic       released;  // set when a break prefix came first
    logic [7:0] code;      // raw scan code, 0xE0 passes as is
  } scan_evt_t;

endpackage

`default_nettype wire

/* verilog/ps2_rx.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ps2 receiver: pin synchronizers, falling edge detect,
// 11 bit frame shifter with start, parity and stop checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module ps2_rx (
  input  logic       clk_i,
  input  logic       rst_n,
  input  logic       ps2_clk,     // async pin
  input  logic       ps2_data,    // async pin
  output logic       byte_valid,  // one cycle, clean frame
  output logic [7:0] byte_data,
  output logic       frame_err    // one cycle, bad frame
);

  localparam int fb    = ps2_pkg::frame_bits;
  localparam int cnt_w = $clog2(fb);

  logic [1:0]       clk_sync;  // two flop synchronizer
  logic [1:0]       dat_sync;
  logic             clk_prev;  // last synchronized clock level
  logic             fall;
  logic [fb-1:0]    shift_q;   // bits so far, newest at the top
  logic [fb-1:0]    frame;     // frame including the bit being sampled
  logic [cnt_w-1:0] bit_cnt;
  logic             last_bit;
  logic             frame_ok;

  // both lines idle high, so reset to 1 to avoid a false edge
  always_ff @(posedge clk_i)
  begin
    if (!rst_n)
    begin
      clk_sync <= 2'b11;
      dat_sync <= 2'b11;
      clk_prev <= 1'b1;
    end
    else
    begin
      clk_sync <= {clk_sync[0], ps2_clk};
      dat_sync <= {dat_sync[0], ps2_data};
      clk_prev <= clk_sync[1];
    end
  end

  assign fall     = clk_prev & ~clk_sync[1];  // keyboard drives data on the high phase
  assign frame    = {dat_sync[1], shift_q[fb-1:1]};  // lsb first, shift right
  assign last_bit = (bit_cnt == cnt_w'(fb - 1));

  // start low, odd parity over data and parity bit, stop high
  assign frame_ok = ~frame[0] & (^frame[9:1]) & frame[10];

  always_ff @(posedge clk_i)
  begin
    if (fall)
    begin
      shift_q <= frame;
    end
    if (fall && last_bit)
    begin
      byte_data <= frame[8:1];  // data held until the next frame
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n)
    begin
      bit_cnt    <= '0;
      byte_valid <= 1'b0;
      frame_err  <= 1'b0;
    end
    else
    begin
      byte_valid <= fall & last_bit & frame_ok;
      frame_err  <= fall & last_bit & ~frame_ok;
      if (fall)
      begin
        bit_cnt <= last_bit ? '0 : bit_cnt + 1'b1;  // wrap after the stop bit
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/ps2_scan_decoder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scan decoder: folds the break prefix into a released flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module ps2_scan_decoder (
  input  logic              clk_i,
  input  logic              rst_n,
  input  logic              byte_valid,
  input  logic [7:0]        byte_data,
  output logic              evt_valid,  // same cycle as byte_valid
  output ps2_pkg::scan_evt_t evt
);

  logic is_break;
  logic brk_pend;  // a break byte is waiting for its code

  assign is_break = (byte_data == ps2_pkg::break_code);

  // every byte updates the flag, only a break leaves it set
  always_ff @(posedge clk_i)
  begin
    if (!rst_n)
    begin
      brk_pend <= 1'b0;
    end
    else if (byte_valid)
    begin
      brk_pend <= is_break;
    end
  end

  // break byte itself never becomes an event
  assign evt_valid = byte_valid & ~is_break;

  always_comb
  begin
    evt.released = brk_pend;
    evt.code     = byte_data;
  end

endmodule

`default_nettype wire

/* verilog/scan_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scan event fifo with sticky overflow
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module scan_fifo #(
  parameter int fifo_depth = 16  // power of two
) (
  input  logic               clk_i,
  input  logic               rst_n,
  input  logic               push,
  input  ps2_pkg::scan_evt_t din,
  input  logic               pop,
  input  logic               clr_overflow,
  output ps2_pkg::scan_evt_t dout,  // head, valid when not empty
  output logic               empty,
  output logic               overflow
);

  localparam int aw = $clog2(fifo_depth);

  ps2_pkg::scan_evt_t mem [fifo_depth];
  logic [aw:0]        wr_ptr;  // extra msb tells full from empty
  logic [aw:0]        rd_ptr;
  logic               full;
  logic               do_push;
  logic               do_pop;

  assign empty   = (wr_ptr == rd_ptr);
  assign full    = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);
  assign do_pop  = pop & ~empty;  // pop on empty ignored
  assign do_push = push & (~full | do_pop);  // a pop frees the slot
  assign dout    = mem[rd_ptr[aw-1:0]];

  always_ff @(posedge clk_i)
  begin
    if (do_push)
    begin
      mem[wr_ptr[aw-1:0]] <= din;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      // a drop in the same cycle as the clear wins
      overflow <= (overflow & ~clr_overflow) | (push & ~do_push);
    end
  end

endmodule

`default_nettype wire

/* verilog/char_store.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// character store: 64 bit words, byte lane writes, registered read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module char_store #(
  parameter int store_words = 512
) (
  input  logic                  clk_i,
  input  hid_bus_pkg::hid_req_t req,
  input  logic                  sel,    // region hit
  output logic [63:0]           rdata   // word of the last selected access
);

  localparam int aw = $clog2(store_words);

  logic [63:0]   mem [store_words];
  logic [aw-1:0] idx;
  logic          access;

  assign idx    = req.addr[aw+2:3];  // byte address to word index
  assign access = sel & req.en;

  // block ram powers up cleared, so blank screen
  initial
  begin
    for (int i = 0; i < store_words; i++)
    begin
      mem[i] = '0;
    end
  end

  // write lands at the request edge, read sees the old word
  always_ff @(posedge clk_i)
  begin
    if (access)
    begin
      for (int b = 0; b < 8; b++)
      begin
        if (req.we[b])
        begin
          mem[idx][b*8 +: 8] <= req.wdata[b*8 +: 8];
        end
      end
      rdata <= mem[idx];  // held until the next hit
    end
  end

endmodule

`default_nettype wire

/* verilog/hid_soc.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hid top: keyboard path, character store, region decode,
// keyboard status register and registered read mux
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module hid_soc #(
  parameter int fifo_depth  = 16,
  parameter int store_words = 512
) (
  input  logic        clk_i,
  input  logic        rst_n,
  input  logic        ps2_clk,
  input  logic        ps2_data,
  input  logic        hid_en,
  input  logic [7:0]  hid_we,
  input  logic [19:0] hid_addr,
  input  logic [63:0] hid_wrdata,
  output logic [63:0] hid_rddata  // valid the cycle after the request
);

  localparam int sel_kbd = 0;  // one-hot bit positions
  localparam int sel_chr = 1;

  hid_bus_pkg::hid_req_t   req;
  hid_bus_pkg::hid_rdata_u status_d, status_q;
  ps2_pkg::scan_evt_t      evt, fifo_dout;
  logic [1:0]  sel, sel_q;  // one-hot over mapped regions
  logic        kbd_wr, pop, clr_flags;
  logic        byte_valid, rx_frame_err, evt_valid;
  logic [7:0]  byte_data;
  logic        fifo_empty, fifo_overflow;
  logic        frame_err_q;  // sticky framing error
  logic [63:0] chr_rdata;

  assign req = '{en: hid_en, we: hid_we, addr: hid_addr, wdata: hid_wrdata};

  assign sel[sel_kbd] = (req.addr[19:15] == hid_bus_pkg::region_kbd);
  assign sel[sel_chr] = (req.addr[19:15] == hid_bus_pkg::region_chr);

  assign kbd_wr    = req.en & (|req.we) & sel[sel_kbd];
  assign pop       = kbd_wr & ~req.addr[14];  // addr[14] low pops
  assign clr_flags = kbd_wr & req.addr[14];   // addr[14] high clears sticky bits

  ps2_rx u_rx (.clk_i, .rst_n, .ps2_clk, .ps2_data, .byte_valid, .byte_data,
               .frame_err(rx_frame_err));

  ps2_scan_decoder u_dec (.clk_i, .rst_n, .byte_valid, .byte_data, .evt_valid, .evt);

  scan_fifo #(.fifo_depth(fifo_depth)) u_fifo (
    .clk_i, .rst_n, .push(evt_valid), .din(evt), .pop, .clr_overflow(clr_flags),
    .dout(fifo_dout), .empty(fifo_empty), .overflow(fifo_overflow));

  char_store #(.store_words(store_words)) u_chr (
    .clk_i, .req, .sel(sel[sel_chr]), .rdata(chr_rdata));

  // status view of the head, code blanked when nothing is queued
  always_comb
  begin
    status_d               = '0;
    status_d.kbd.overflow  = fifo_overflow;
    status_d.kbd.frame_err = frame_err_q;
    status_d.kbd.empty     = fifo_empty;
    status_d.kbd.released  = ~fifo_empty & fifo_dout.released;
    status_d.kbd.code      = fifo_empty ? 8'h00 : fifo_dout.code;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n)
    begin
      frame_err_q <= 1'b0;
      sel_q       <= '0;  // read word is zero out of reset
    end
    else
    begin
      frame_err_q <= (frame_err_q & ~clr_flags) | rx_frame_err;
      if (req.en) sel_q <= sel;  // unmapped request leaves sel_q zero
    end
  end

  // snapshot at the request, before any pop takes effect
  always_ff @(posedge clk_i)
  begin
    if (req.en && sel[sel_kbd]) status_q <= status_d;
  end

  // or of the selected source, holds until the next request
  always_comb
  begin
    hid_rddata = '0;
    if (sel_q[sel_kbd]) hid_rddata |= status_q.raw;
    if (sel_q[sel_chr]) hid_rddata |= chr_rdata;
  end

endmodule

`default_nettype wire

/* sim/tb_hid_soc.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hid_soc testbench with clock, reset, ps2 frame driver and bus tasks,
// random store traffic and a reference model with its checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_hid_soc;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int fifo_depth  = 16;
  localparam int store_words = 512;
  localparam int n_make      = 8;
  localparam int n_brk       = 3;
  localparam int n_rand      = 200;
  localparam int n_frames    = n_make + 2 * n_brk + 1 + fifo_depth + 3;
  localparam int n_bus       = n_rand + 4 * n_frames + 16;  // pops, status reads, clears
  localparam int cycle_limit = n_frames * 300 + n_bus * 4 + 2000;
  localparam logic [19:0] kbd_pop = {hid_bus_pkg::region_kbd, 15'h0000};
  localparam logic [19:0] kbd_clr = {hid_bus_pkg::region_kbd, 15'h4000};  // addr[14] set

  logic        clk_i, rst_n, ps2_clk, ps2_data, hid_en;
  logic [7:0]  hid_we;
  logic [19:0] hid_addr;
  logic [63:0] hid_wrdata, hid_rddata;

  integer seed = 32'h3aee_6cd4;
  int     status_errs, word_errs, cycles;

  // reference model state
  ps2_pkg::scan_evt_t evt_q[$];
  logic               brk_m, ferr_m, ovf_m;
  logic [63:0]        store_m [int];

  hid_soc #(.fifo_depth(fifo_depth), .store_words(store_words)) uut (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;  // 8 ns period
  end

  // ends a stuck run
  initial
  begin
    cycles = 0;
    while (cycles < cycle_limit)
    begin
      @(posedge clk_i);
      cycles++;
    end
    $display("run timed out after %0d cycles", cycle_limit);
    $display("Test failed");
    $finish;
  end

  // leaves the caller 1 ns past a rising edge
  task automatic step(input int n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  function automatic logic [7:0] rand_code();
    logic [7:0] c;
    c = 8'($random(seed));
    if (c == ps2_pkg::break_code) c = 8'h1C;  // keep make codes plain
    return c;
  endfunction

  function automatic logic [4:0] unmapped_region();
    logic [4:0] r;
    r = 5'($random(seed));
    if (r == hid_bus_pkg::region_kbd || r == hid_bus_pkg::region_chr) r = r + 5'd2;
    return r;
  endfunction

  function automatic logic [63:0] model_word(input int idx);
    return store_m.exists(idx) ? store_m[idx] : 64'h0;  // unwritten reads zero
  endfunction

  function automatic void model_write(input logic [19:0] addr, input logic [7:0] we,
                                      input logic [63:0] data);
    logic [63:0] w;
    int          idx;
    idx = int'(addr[11:3]);
    w   = model_word(idx);
    for (int b = 0; b < 8; b++)
    begin
      if (we[b]) w[b*8 +: 8] = data[b*8 +: 8];  // lane merge
    end
    store_m[idx] = w;
  endfunction

  // what one received byte does to the keyboard side
  function automatic void model_rx(input logic [7:0] data, input bit bad);
    ps2_pkg::scan_evt_t ev;
    if (bad)
    begin
      ferr_m = 1'b1;  // bad frame never reaches the decoder
    end
    else if (data == ps2_pkg::break_code)
    begin
      brk_m = 1'b1;
    end
    else
    begin
      ev.released = brk_m;
      ev.code     = data;
      if (evt_q.size() < fifo_depth) evt_q.push_back(ev);
      else ovf_m = 1'b1;  // dropped when full
      brk_m = 1'b0;
    end
  endfunction

  function automatic hid_bus_pkg::hid_rdata_u model_status();
    hid_bus_pkg::hid_rdata_u s;
    s.raw          = '0;
    s.kbd.overflow = ovf_m;
    s.kbd.frame_err = ferr_m;
    s.kbd.empty    = (evt_q.size() == 0);
    if (evt_q.size() > 0)
    begin
      s.kbd.released = evt_q[0].released;
      s.kbd.code     = evt_q[0].code;
    end
    return s;
  endfunction

  task automatic check_status(input hid_bus_pkg::hid_rdata_u got,
                              input hid_bus_pkg::hid_rdata_u exp, input string what);
    if (got !== exp)
    begin
      status_errs++;
      $display("[ERROR] %0d ns: %s, status got %h expected %h", $time, what, got.raw, exp.raw);
    end
  endtask

  task automatic check_word(input logic [63:0] got, input logic [63:0] exp,
                            input string what);
    if (got !== exp)
    begin
      word_errs++;
      $display("[ERROR] %0d ns: %s, word got %h expected %h", $time, what, got, exp);
    end
  endtask

  // frame goes lsb first with data set while the clock is high
  task automatic send_frame(input logic [7:0] data, input bit bad);
    logic [10:0] bits;
    bits = {1'b1, (~^data) ^ bad, data, 1'b0};  // stop, odd parity, data, start
    for (int i = 0; i < ps2_pkg::frame_bits; i++)
    begin
      ps2_data = bits[i];
      step(12);
      ps2_clk = 1'b0;  // dut samples on this edge
      step(12);
      ps2_clk = 1'b1;
    end
    model_rx(data, bad);  // 12 idle cycles past the stop bit cover the 5 cycle path
  endtask

  task automatic bus_write(input logic [19:0] addr, input logic [7:0] we,
                           input logic [63:0] data);
    hid_en     = 1'b1;
    hid_we     = we;
    hid_addr   = addr;
    hid_wrdata = data;
    step(1);
    hid_en = 1'b0;
    hid_we = 8'h00;
  endtask

  // data sampled one cycle after the request
  task automatic bus_read(input logic [19:0] addr, output logic [63:0] data);
    hid_en   = 1'b1;
    hid_we   = 8'h00;
    hid_addr = addr;
    step(1);
    hid_en = 1'b0;
    data   = hid_rddata;
  endtask

  task automatic expect_status(input string what);
    hid_bus_pkg::hid_rdata_u got;
    bus_read(kbd_pop, got.raw);
    check_status(got, model_status(), what);
  endtask

  task automatic pop_event();
    bus_write(kbd_pop, 8'h01, 64'h0);
    if (evt_q.size() > 0) void'(evt_q.pop_front());  // empty pop is a no-op
  endtask

  task automatic clear_flags();
    bus_write(kbd_clr, 8'hFF, 64'h0);
    ferr_m = 1'b0;
    ovf_m  = 1'b0;
  endtask

  // reads and pops until the model queue runs dry
  task automatic drain(input string what);
    while (evt_q.size() > 0)
    begin
      expect_status(what);
      pop_event();
    end
    expect_status({what, ", drained"});
  endtask

  task automatic chr_read(input logic [19:0] addr);
    logic [63:0] rd;
    bus_read(addr, rd);
    check_word(rd, model_word(int'(addr[11:3])), "store read");
  endtask

  // one random access over walking one word indices so reads hit earlier writes
  task automatic random_op();
    int          kind;
    int          wbit;
    logic [19:0] addr;
    logic [7:0]  we;
    logic [63:0] data, rd;
    kind        = $unsigned($random(seed)) % 6;
    wbit        = $unsigned($random(seed)) % 10;
    addr        = {hid_bus_pkg::region_chr, 15'($random(seed))};
    addr[11:3]  = (wbit == 9) ? 9'd0 : 9'd1 << wbit;  // word 0 or one index bit set
    we          = 8'($random(seed));
    if (we == 8'h00) we = 8'hFF;  // zero lanes would be a read
    data        = {$random(seed), $random(seed)};
    case (kind)
      0, 1:
      begin
        bus_write(addr, we, data);
        model_write(addr, we, data);
      end
      2, 3: chr_read(addr);
      4:
      begin
        bus_read({unmapped_region(), addr[14:0]}, rd);
        check_word(rd, 64'h0, "unmapped read");
      end
      default: bus_write({unmapped_region(), addr[14:0]}, we, data);  // must go nowhere
    endcase
  endtask

  initial
  begin
    rst_n       = 1'b0;
    ps2_clk     = 1'b1;  // idle lines high
    ps2_data    = 1'b1;
    hid_en      = 1'b0;
    hid_we      = 8'h00;
    hid_addr    = 20'h0;
    hid_wrdata  = 64'h0;
    status_errs = 0;
    word_errs   = 0;
    brk_m       = 1'b0;
    ferr_m      = 1'b0;
    ovf_m       = 1'b0;
    step(2);
    rst_n = 1'b1;
    check_word(hid_rddata, 64'h0, "read data after reset");
    expect_status("after reset");
    chr_read({hid_bus_pkg::region_chr, 15'h0128});

    // make codes in order
    repeat (n_make) send_frame(rand_code(), 1'b0);
    drain("make codes");

    // break prefix folds into the next code
    repeat (n_brk)
    begin
      send_frame(ps2_pkg::break_code, 1'b0);
      send_frame(rand_code(), 1'b0);
      expect_status("break pair");
      pop_event();
      expect_status("break byte not queued");
    end

    send_frame(rand_code(), 1'b1);
    expect_status("bad parity");
    clear_flags();
    expect_status("frame error cleared");

    repeat (fifo_depth + 3) send_frame(rand_code(), 1'b0);
    expect_status("fifo overflow");
    drain("overflow drain");
    clear_flags();
    expect_status("overflow cleared");

    repeat (n_rand) random_op();

    $display("error counts: %0d status, %0d word", status_errs, word_errs);
    if (status_errs + word_errs == 0)
    begin
      $display("Test completed successfully");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
verilog/hid_bus_pkg.sv
verilog/ps2_pkg.sv
verilog/ps2_rx.sv
verilog/ps2_scan_decoder.sv
verilog/scan_fifo.sv
verilog/char_store.sv
verilog/hid_soc.sv
sim/tb_hid_soc.sv

/* Bender.yml */
package:
  name: hid_soc

sources:
  - verilog/hid_bus_pkg.sv
  - verilog/ps2_pkg.sv
  - verilog/ps2_rx.sv
  - verilog/ps2_scan_decoder.sv
  - verilog/scan_fifo.sv
  - verilog/char_store.sv
  - verilog/hid_soc.sv
  - target: simulation
    files:
      - sim/tb_hid_soc.sv
